//--- build.f
+incdir+logic
logic/ooo_types_pkg.sv
logic/fu_result_if.sv
logic/cb_write_if.sv
logic/ooo_issue_stage.sv
logic/ooo_alu_unit.sv
logic/ooo_mul_unit.sv
logic/ooo_writeback_stage.sv
logic/ooo_completion_buffer.sv
logic/ooo_backend_top.sv
sim/ooo_backend_props.sv
sim/ooo_backend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the back end testbench, exit status is the verdict
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module ooo_backend_tb \
    -f build.f -o ooo_backend_sim &&
  ./obj_dir/ooo_backend_sim || exit 1

//--- sim/ooo_backend_tb.sv
// back end testbench
`timescale 1ns/10ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_backend_tb;

  import ooo_types_pkg::*;

  // instruction count over all tasks, sizes the timeout
  localparam int n_instr        = 37;
  localparam int timeout_cycles = 16 + n_instr * (`OOO_MUL_STAGES + 1) * 4 + 100;

  // expected retire record
  typedef struct packed {
    logic [4:0]           rd;
    logic                 wen;
    logic                 chk_data; // branches leave data undefined
    logic [`OOO_XLEN-1:0] data;
    logic                 exc;
    logic                 redir;
    logic [`OOO_XLEN-1:0] target;   // only meaningful on redirect
  } ret_rec_t;

  logic                 CLK;
  logic                 nRST;
  logic                 in_valid;
  logic                 in_ready;
  op_t                  in_op;
  logic [4:0]           in_rd;
  logic [`OOO_XLEN-1:0] in_pc, in_src_a, in_src_b, in_imm;
  logic                 in_pred_taken;
  logic                 ret_valid, ret_ready;
  logic [4:0]           ret_rd;
  logic                 ret_wen, ret_exception, ret_redirect;
  logic [`OOO_XLEN-1:0] ret_data, ret_target;

  ret_rec_t             exp_q [$]; // reference model, program order
  logic [31:0]          lfsr = 32'hb569;
  logic [`OOO_XLEN-1:0] pc_cnt = 32'h1000;
  int                   cycles = 0;

  ooo_backend_top ooo_backend_top_i (.CLK, .nRST, .in_valid, .in_ready, .in_op, .in_rd,
    .in_pc, .in_src_a, .in_src_b, .in_imm, .in_pred_taken, .ret_valid, .ret_ready,
    .ret_rd, .ret_wen, .ret_data, .ret_exception, .ret_redirect, .ret_target);

  always #5 CLK = ~CLK; // 10 ns period

  task automatic fail_and_stop();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    fail_and_stop();
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    fail_and_stop();
  endtask

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // expected retirement, straight from the result-kind rules
  function automatic ret_rec_t model(input op_t op, input logic [4:0] rd,
                                     input logic [31:0] pc, a, b, imm, input logic pred);
    ret_rec_t    r;
    logic        reg_wen;
    logic        take;
    logic [31:0] tgt;
    r        = '0;
    r.rd     = rd;
    r.chk_data = 1'b1;
    reg_wen  = 1'b1;
    tgt      = pc + imm;
    case (op)
      OP_ADD: r.data = a + b;
      OP_SUB: r.data = a - b;
      OP_XOR: r.data = a ^ b;
      OP_MUL: r.data = a * b;  // low word only
      OP_JAL: begin
        r.data   = pc + 32'd4; // link
        r.redir  = 1'b1;
        r.target = tgt;
        if (tgt[1:0] != 2'b00) begin
          r.exc   = 1'b1;
          r.data  = pc;
          r.redir = 1'b0;
          reg_wen = 1'b0;
        end
      end
      default: begin // beq
        take       = (a == b);
        reg_wen    = 1'b0;
        r.chk_data = 1'b0;
        r.redir    = (take != pred);
        r.target   = take ? tgt : pc + 32'd4;
        if (take && tgt[1:0] != 2'b00) begin
          r.exc      = 1'b1;
          r.data     = pc;
          r.chk_data = 1'b1;
          r.redir    = 1'b0;
        end
      end
    endcase
    r.wen = reg_wen && (rd != 5'd0); // x0 never written
    return r;
  endfunction

  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  // put an instruction on the port, record its expected retirement
  task automatic present(input op_t op, input logic [4:0] rd, input logic [31:0] a, b, imm,
                         input logic pred);
    in_valid      = 1'b1;
    in_op         = op;
    in_rd         = rd;
    in_pc         = pc_cnt;
    in_src_a      = a;
    in_src_b      = b;
    in_imm        = imm;
    in_pred_taken = pred;
    exp_q.push_back(model(op, rd, pc_cnt, a, b, imm, pred));
    pc_cnt += 32'd4;
  endtask

  task automatic send(input op_t op, input logic [4:0] rd, input logic [31:0] a, b, imm,
                      input logic pred);
    present(op, rd, a, b, imm, pred);
    while (!in_ready)
      step();
    step();          // transfer on this edge
    in_valid = 1'b0;
  endtask

  task automatic drain();
    ret_ready = 1'b1;
    while (exp_q.size() != 0)
      step();
  endtask

  task automatic alu_ops();
    for (int i = 0; i < 9; i++)
      send(op_t'(i % 3), 5'(i + 1), next_bits(32), next_bits(32), 32'h0, 1'b0);
    send(OP_ADD, 5'd0, next_bits(32), next_bits(32), 32'h0, 1'b0); // x0 write
    drain();
  endtask

  task automatic mul_order();
    send(OP_MUL, 5'd5, next_bits(32), next_bits(32), 32'h0, 1'b0);
    send(OP_ADD, 5'd6, next_bits(32), next_bits(32), 32'h0, 1'b0); // done before the mul
    send(OP_ADD, 5'd7, next_bits(32), next_bits(32), 32'h0, 1'b0);
    for (int i = 0; i < 3; i++) // back to back, three in flight
      send(OP_MUL, 5'(i + 8), next_bits(32), next_bits(32), 32'h0, 1'b0);
    send(OP_ADD, 5'd11, next_bits(32), next_bits(32), 32'h0, 1'b0);
    drain();
  endtask

  task automatic branch_cases();
    send(OP_BEQ, 5'd3, 32'h55, 32'h55, 32'h20, 1'b1); // taken, predicted
    send(OP_BEQ, 5'd3, 32'h55, 32'h55, 32'h20, 1'b0); // taken, mispredicted
    send(OP_BEQ, 5'd3, 32'h55, 32'h56, 32'h20, 1'b0); // not taken, predicted
    send(OP_BEQ, 5'd3, 32'h55, 32'h56, 32'h20, 1'b1); // not taken, mispredicted
    drain();
  endtask

  task automatic jump_cases();
    send(OP_JAL, 5'd1, 32'h0, 32'h0, 32'h100, 1'b0);
    send(OP_JAL, 5'd1, 32'h0, 32'h0, 32'h102, 1'b0); // misaligned target
    drain();
  endtask

  task automatic back_pressure();
    logic [31:0] r;
    int          extra;
    ret_ready = 1'b0;
    for (int i = 0; i < `OOO_CB_DEPTH; i++) begin
      assert (in_ready) else report_mismatch($sformatf("in_ready low at %0d outstanding", i));
      send(op_t'(i % 4), 5'(i + 12), next_bits(32), next_bits(32), 32'h0, 1'b0);
    end
    present(OP_XOR, 5'd20, next_bits(32), next_bits(32), 32'h0, 1'b0);
    repeat (4) begin // full buffer holds the port
      assert (!in_ready) else report_mismatch("in_ready high with a full buffer");
      step();
    end
    extra = 5;
    while (extra > 0 || exp_q.size() != 0) begin
      r         = next_bits(1);
      ret_ready = r[0];
      if (in_valid && in_ready) begin
        step(); // accepted on this edge
        if (extra > 0) begin
          present(op_t'(extra % 4), 5'(extra + 20), next_bits(32), next_bits(32), 32'h0, 1'b0);
          extra--;
        end else begin
          in_valid = 1'b0;
        end
      end else begin
        step();
      end
    end
    ret_ready = 1'b1;
  endtask

  // retire monitor, mid cycle so outputs and ret_ready are settled
  always @(negedge CLK) begin
    ret_rec_t e;
    if (nRST && ret_valid && ret_ready) begin
      assert (exp_q.size() > 0) else abort_run("a retirement came with nothing outstanding");
      e = exp_q.pop_front();
      assert (ret_rd == e.rd)
        else report_mismatch($sformatf("ret_rd %0d, expected %0d", ret_rd, e.rd));
      assert (ret_wen == e.wen)
        else report_mismatch($sformatf("ret_wen %0b, expected %0b", ret_wen, e.wen));
      assert (!e.chk_data || ret_data == e.data)
        else report_mismatch($sformatf("ret_data %h, expected %h", ret_data, e.data));
      assert (ret_exception == e.exc)
        else report_mismatch($sformatf("ret_exception %0b, expected %0b", ret_exception, e.exc));
      assert (ret_redirect == e.redir)
        else report_mismatch($sformatf("ret_redirect %0b, expected %0b", ret_redirect, e.redir));
      assert (!e.redir || ret_target == e.target)
        else report_mismatch($sformatf("ret_target %h, expected %h", ret_target, e.target));
    end
  end

  // hang guard
  always @(posedge CLK) begin
    cycles++;
    if (cycles > timeout_cycles)
      abort_run($sformatf("the run hung, still busy after %0d cycles", timeout_cycles));
  end

  initial begin
    CLK           = 1'b0;
    nRST          = 1'b0;
    in_valid      = 1'b0;
    in_op         = OP_ADD;
    in_rd         = '0;
    in_pc         = '0;
    in_src_a      = '0;
    in_src_b      = '0;
    in_imm        = '0;
    in_pred_taken = 1'b0;
    ret_ready     = 1'b1;
    repeat (16) @(posedge CLK);
    #1 nRST = 1'b1;
    assert (in_ready && !ret_valid) else report_mismatch("in_ready or ret_valid wrong after reset");
    alu_ops();
    mul_order();
    branch_cases();
    jump_cases();
    back_pressure();
    repeat (3) step(); // nothing stray after the last retire
    if (exp_q.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      abort_run("instructions were left without retiring");
    end
  end

endmodule

`default_nettype wire

//--- sim/ooo_backend_props.sv
// completion buffer properties
`timescale 1ns/10ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_backend_props (
  input logic                     CLK,
  input logic                     nRST,
  input logic                     alloc,
  input logic [`OOO_CB_IDX_W-1:0] head,
  input logic [`OOO_CB_IDX_W-1:0] tail,
  input logic [`OOO_CB_IDX_W:0]   count,
  input logic                     ret_valid,
  input logic                     ret_ready,
  input logic [4:0]               ret_rd,
  input logic                     ret_wen,
  input logic                     ret_exception,
  input logic                     ret_redirect,
  input logic [`OOO_XLEN-1:0]     ret_data,
  input logic [`OOO_XLEN-1:0]     ret_target
);

  localparam logic [`OOO_CB_IDX_W:0] full_count = (`OOO_CB_IDX_W+1)'(`OOO_CB_DEPTH);

  // occupancy agrees with the pointer distance, full wraps tail onto head
  count_matches_pointers: assert property (@(posedge CLK) disable iff (!nRST)
    (tail - head) == count[`OOO_CB_IDX_W-1:0]) else $error("count off from pointers");

  // stalled head keeps its payload
  retire_held: assert property (@(posedge CLK) disable iff (!nRST)
    (ret_valid && !ret_ready) |=> (ret_valid && $stable(ret_rd) && $stable(ret_wen) &&
      $stable(ret_data) && $stable(ret_exception) && $stable(ret_redirect) &&
      $stable(ret_target))) else $error("retire payload changed while stalled");

  no_alloc_when_full: assert property (@(posedge CLK) disable iff (!nRST)
    (count == full_count) |-> !alloc) else $error("alloc while full");

  count_bounded: assert property (@(posedge CLK) disable iff (!nRST)
    count <= full_count) else $error("count above depth");

endmodule

bind ooo_completion_buffer ooo_backend_props props_i (
  .CLK, .nRST, .alloc, .head, .tail, .count, .ret_valid, .ret_ready, .ret_rd, .ret_wen,
  .ret_exception, .ret_redirect, .ret_data, .ret_target
);

`default_nettype wire

//--- logic/ooo_backend_top.sv
// out-of-order back end top
`timescale 1ns/10ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_backend_top (
  input  logic                  CLK,
  input  logic                  nRST,
  // instruction in
  input  logic                  in_valid,
  output logic                  in_ready,
  input  ooo_types_pkg::op_t    in_op,
  input  logic [4:0]            in_rd,
  input  logic [`OOO_XLEN-1:0]  in_pc,
  input  logic [`OOO_XLEN-1:0]  in_src_a,
  input  logic [`OOO_XLEN-1:0]  in_src_b,
  input  logic [`OOO_XLEN-1:0]  in_imm,
  input  logic                  in_pred_taken,
  // retire out
  output logic                  ret_valid,
  input  logic                  ret_ready,
  output logic [4:0]            ret_rd,
  output logic                  ret_wen,
  output logic [`OOO_XLEN-1:0]  ret_data,
  output logic                  ret_exception,
  output logic                  ret_redirect,
  output logic [`OOO_XLEN-1:0]  ret_target
);

  import ooo_types_pkg::*;

  issue_t                   in_pkt;
  issue_t                   iss;
  logic                     alloc, alloc_ready;
  logic [`OOO_CB_IDX_W-1:0] tail_index, iss_index;
  logic                     alu_valid, mul_valid;
  res_kind_t                kind;
  logic                     taken, pred_taken;
  logic [`OOO_XLEN-1:0]     target;

  fu_result_if alu_res ();
  fu_result_if mul_res ();
  cb_write_if  cbw ();

  assign in_pkt = '{op: in_op, rd: in_rd, pc: in_pc, src_a: in_src_a, src_b: in_src_b,
                    imm: in_imm, pred_taken: in_pred_taken};

  ooo_issue_stage issue_i (.CLK, .nRST, .in_valid, .in_ready, .in(in_pkt), .alloc_ready,
                           .tail_index, .alloc, .alu_valid, .mul_valid, .iss, .iss_index);

  ooo_alu_unit alu_i (.CLK, .nRST, .valid(alu_valid), .iss, .iss_index, .res(alu_res.src),
                      .kind, .taken, .pred_taken, .target);

  ooo_mul_unit mul_i (.CLK, .nRST, .valid(mul_valid), .iss, .iss_index, .res(mul_res.src));

  ooo_writeback_stage wb_i (.res(alu_res.dst), .kind, .taken, .pred_taken, .target,
                            .cbw(cbw.wb));

  // multiplier bypasses writeback into port b
  ooo_completion_buffer cb_i (.CLK, .nRST, .alloc, .alloc_ready, .tail_index, .wa(cbw.cb),
                              .wb(mul_res.dst), .ret_valid, .ret_ready, .ret_rd, .ret_wen,
                              .ret_data, .ret_exception, .ret_redirect, .ret_target);

endmodule

`default_nettype wire

//--- logic/ooo_completion_buffer.sv
// completion buffer with in-order retire
`timescale 1ns/10ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_completion_buffer (
  input  logic                     CLK,
  input  logic                     nRST,
  // allocation from issue
  input  logic                     alloc,
  output logic                     alloc_ready,
  output logic [`OOO_CB_IDX_W-1:0] tail_index,
  // write ports, a from writeback, b from multiplier
  cb_write_if.cb                   wa,
  fu_result_if.dst                 wb,
  // retire port
  output logic                     ret_valid,
  input  logic                     ret_ready,
  output logic [4:0]               ret_rd,
  output logic                     ret_wen,
  output logic [`OOO_XLEN-1:0]     ret_data,
  output logic                     ret_exception,
  output logic                     ret_redirect,
  output logic [`OOO_XLEN-1:0]     ret_target
);

  logic [`OOO_CB_IDX_W-1:0] head;
  logic [`OOO_CB_IDX_W-1:0] tail;
  logic [`OOO_CB_IDX_W:0]   count;  // one extra bit for full
  logic                     retire;

  // per-entry state
  logic [`OOO_CB_DEPTH-1:0] done;
  logic [`OOO_CB_DEPTH-1:0] reg_wen_q;
  logic [`OOO_CB_DEPTH-1:0] exc_q;
  logic [`OOO_CB_DEPTH-1:0] redir_q;
  logic [4:0]               rd_q     [`OOO_CB_DEPTH];
  logic [`OOO_XLEN-1:0]     data_q   [`OOO_CB_DEPTH];
  logic [`OOO_XLEN-1:0]     target_q [`OOO_CB_DEPTH];

  assign alloc_ready = (count != (`OOO_CB_IDX_W+1)'(`OOO_CB_DEPTH));
  assign tail_index  = tail;
  assign ret_valid   = done[head]; // freed slots have done clear
  assign retire      = ret_valid & ret_ready;

  // pointers wrap with the index width
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc)
        tail <= tail + 1'b1;
      if (retire)
        head <= head + 1'b1;
      case ({alloc, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ; // both or neither, no change
      endcase
    end
  end

  // completion flags, writes never hit the head being retired
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      done <= '0;
    end else begin
      if (wa.wen)
        done[wa.index] <= 1'b1;
      if (wb.valid)
        done[wb.index] <= 1'b1;
      if (retire)
        done[head] <= 1'b0; // slot free again
    end
  end

  always_ff @(posedge CLK) begin
    if (wa.wen) begin
      rd_q[wa.index]      <= wa.rd;
      reg_wen_q[wa.index] <= wa.reg_wen;
      data_q[wa.index]    <= wa.data;
      exc_q[wa.index]     <= wa.exception;
      redir_q[wa.index]   <= wa.redirect;
      target_q[wa.index]  <= wa.target;
    end
    // multiply results always write rd, never fault
    if (wb.valid) begin
      rd_q[wb.index]      <= wb.rd;
      reg_wen_q[wb.index] <= 1'b1;
      data_q[wb.index]    <= wb.wdata;
      exc_q[wb.index]     <= 1'b0;
      redir_q[wb.index]   <= 1'b0;
      target_q[wb.index]  <= wb.pc + (`OOO_XLEN)'(4); // fall-through, no redirect
    end
  end

  assign ret_rd        = rd_q[head];
  assign ret_wen       = reg_wen_q[head] & (rd_q[head] != 5'd0); // x0 not written
  assign ret_data      = data_q[head];
  assign ret_exception = exc_q[head];
  assign ret_redirect  = redir_q[head];
  assign ret_target    = target_q[head];

endmodule

`default_nettype wire

//--- logic/ooo_writeback_stage.sv
// alu writeback and branch resolution
`timescale 1ns/10ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_writeback_stage (
  fu_result_if.dst                 res,
  input  ooo_types_pkg::res_kind_t kind,
  input  logic                     taken,
  input  logic                     pred_taken,
  input  logic [`OOO_XLEN-1:0]     target,
  cb_write_if.wb                   cbw
);

  import ooo_types_pkg::*;

  logic                 is_branch;
  logic                 is_jump;
  logic                 mispredict;
  logic                 misaligned;
  logic [`OOO_XLEN-1:0] pc_plus4; // fall-through pc

  assign is_branch = (kind == RES_BRANCH);
  assign is_jump   = (kind == RES_JUMP);
  assign pc_plus4  = res.pc + (`OOO_XLEN)'(4);

  // prediction vs. actual outcome
  assign mispredict = is_branch & (taken ^ pred_taken);

  // only a target we actually go to can fault
  assign misaligned = (is_jump | (is_branch & taken)) & (target[1:0] != 2'b00);

  assign cbw.wen       = res.valid;
  assign cbw.index     = res.index;
  assign cbw.rd        = res.rd;
  assign cbw.exception = misaligned;
  assign cbw.reg_wen   = ~is_branch & ~misaligned;   // branches never write rd
  assign cbw.data      = misaligned ? res.pc : res.wdata; // faulting pc reported as data
  assign cbw.redirect  = ~misaligned & (is_jump | mispredict);

  // not-taken branch resumes at pc+4
  assign cbw.target = (is_branch & ~taken) ? pc_plus4 : target;

endmodule

`default_nettype wire

//--- logic/ooo_mul_unit.sv
// pipelined multiplier, low word
`timescale 1ns/10ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_mul_unit (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     valid,
  input  ooo_types_pkg::issue_t    iss,
  input  logic [`OOO_CB_IDX_W-1:0] iss_index,
  fu_result_if.src                 res
);

  // tag pipeline beside the product
  logic [`OOO_MUL_STAGES-1:0] vld;
  logic [`OOO_CB_IDX_W-1:0]   idx_q [`OOO_MUL_STAGES];
  logic [4:0]                 rd_q  [`OOO_MUL_STAGES];
  logic [`OOO_XLEN-1:0]       pc_q  [`OOO_MUL_STAGES];

  // product datapath, low word = ll + (cross << half)
  logic [`OOO_XLEN-1:0]   s1_ll;  // a_lo * b_lo
  logic [`OOO_XLEN/2-1:0] s1_x1;  // a_lo * b_hi, low half
  logic [`OOO_XLEN/2-1:0] s1_x2;  // a_hi * b_lo, low half
  logic [`OOO_XLEN-1:0]   s2_ll;
  logic [`OOO_XLEN/2-1:0] s2_x;   // summed cross terms
  logic [`OOO_XLEN-1:0]   s3_prod;

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST)
      vld <= '0;
    else
      vld <= {vld[`OOO_MUL_STAGES-2:0], valid}; // one valid per stage
  end

  always_ff @(posedge CLK) begin
    idx_q[0] <= iss_index;
    rd_q[0]  <= iss.rd;
    pc_q[0]  <= iss.pc;
    for (int i = 1; i < `OOO_MUL_STAGES; i++) begin
      idx_q[i] <= idx_q[i-1];
      rd_q[i]  <= rd_q[i-1];
      pc_q[i]  <= pc_q[i-1];
    end
  end

  always_ff @(posedge CLK) begin
    // stage 1, partial products
    s1_ll   <= iss.src_a[`OOO_XLEN/2-1:0] * iss.src_b[`OOO_XLEN/2-1:0];
    s1_x1   <= (`OOO_XLEN/2)'(iss.src_a[`OOO_XLEN/2-1:0] * iss.src_b[`OOO_XLEN-1:`OOO_XLEN/2]);
    s1_x2   <= (`OOO_XLEN/2)'(iss.src_a[`OOO_XLEN-1:`OOO_XLEN/2] * iss.src_b[`OOO_XLEN/2-1:0]);
    // stage 2, fold cross terms
    s2_ll   <= s1_ll;
    s2_x    <= s1_x1 + s1_x2;
    // stage 3, final add
    s3_prod <= s2_ll + {s2_x, {(`OOO_XLEN/2){1'b0}}};
  end

  assign res.valid = vld[`OOO_MUL_STAGES-1];
  assign res.index = idx_q[`OOO_MUL_STAGES-1];
  assign res.rd    = rd_q[`OOO_MUL_STAGES-1];
  assign res.pc    = pc_q[`OOO_MUL_STAGES-1];
  assign res.wdata = s3_prod;

endmodule

`default_nettype wire

//--- logic/ooo_alu_unit.sv
// single cycle alu
`timescale 1ns/10ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_alu_unit (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       valid,
  input  ooo_types_pkg::issue_t      iss,
  input  logic [`OOO_CB_IDX_W-1:0]   iss_index,
  fu_result_if.src                   res,
  // branch / jump side info for writeback
  output ooo_types_pkg::res_kind_t   kind,
  output logic                       taken,
  output logic                       pred_taken,
  output logic [`OOO_XLEN-1:0]       target
);

  import ooo_types_pkg::*;

  logic [`OOO_XLEN-1:0] result;
  logic [`OOO_XLEN-1:0] tgt;    // pc relative target
  res_kind_t            kind_c;
  logic                 taken_c;

  always_comb begin
    result = '0;      // branches write nothing
    kind_c = RES_REG;
    case (iss.op)
      OP_ADD: result = iss.src_a + iss.src_b;
      OP_SUB: result = iss.src_a - iss.src_b;
      OP_XOR: result = iss.src_a ^ iss.src_b;
      OP_BEQ: kind_c = RES_BRANCH;
      OP_JAL: begin
        result = iss.pc + (`OOO_XLEN)'(4); // link value
        kind_c = RES_JUMP;
      end
      default: ; // mul never dispatched here
    endcase
  end

  assign taken_c = (iss.op == OP_BEQ) & (iss.src_a == iss.src_b);
  assign tgt     = iss.pc + iss.imm;

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST)
      res.valid <= 1'b0;
    else
      res.valid <= valid;
  end

  // result register
  always_ff @(posedge CLK) begin
    res.index  <= iss_index;
    res.rd     <= iss.rd;
    res.wdata  <= result;
    res.pc     <= iss.pc;
    kind       <= kind_c;
    taken      <= taken_c;
    pred_taken <= iss.pred_taken;
    target     <= tgt;
  end

endmodule

`default_nettype wire

//--- logic/ooo_issue_stage.sv
// instruction issue and dispatch
`timescale 1ns/10ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_issue_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  // decoded instruction in
  input  logic                     in_valid,
  output logic                     in_ready,
  input  ooo_types_pkg::issue_t    in,
  // buffer allocation
  input  logic                     alloc_ready,
  input  logic [`OOO_CB_IDX_W-1:0] tail_index,
  output logic                     alloc,
  // dispatch to units
  output logic                     alu_valid,
  output logic                     mul_valid,
  output ooo_types_pkg::issue_t    iss,
  output logic [`OOO_CB_IDX_W-1:0] iss_index
);

  import ooo_types_pkg::*;

  logic iss_full; // issue register holds an instruction

  // register drains every cycle, only a full buffer blocks
  assign in_ready = alloc_ready;
  assign alloc    = in_valid & in_ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST)
      iss_full <= 1'b0;
    else
      iss_full <= alloc;
  end

  // payload, tagged with the slot allocated this edge
  always_ff @(posedge CLK) begin
    if (alloc) begin
      iss       <= in;
      iss_index <= tail_index;
    end
  end

  // steer by opcode
  assign mul_valid = iss_full & (iss.op == OP_MUL);
  assign alu_valid = iss_full & (iss.op != OP_MUL);

endmodule

`default_nettype wire

//--- logic/cb_write_if.sv
// resolved writeback into completion buffer
`timescale 1ns/10ps
`default_nettype none

`include "ooo_cfg.svh"

interface cb_write_if;

  logic                     wen;
  logic [`OOO_CB_IDX_W-1:0] index;
  logic [4:0]               rd;
  logic                     reg_wen;   // rd gets written at retire
  logic [`OOO_XLEN-1:0]     data;
  logic                     exception; // misaligned target
  logic                     redirect;  // front end must refetch
  logic [`OOO_XLEN-1:0]     target;

  modport wb (output wen, index, rd, reg_wen, data, exception, redirect, target);
  modport cb (input wen, index, rd, reg_wen, data, exception, redirect, target);

endinterface

`default_nettype wire

//--- logic/fu_result_if.sv
// execution unit result bus
`timescale 1ns/10ps
`default_nettype none

`include "ooo_cfg.svh"

// no ready, every consumer always takes it
interface fu_result_if;

  logic                     valid;
  logic [`OOO_CB_IDX_W-1:0] index; // completion buffer slot
  logic [4:0]               rd;
  logic [`OOO_XLEN-1:0]     wdata;
  logic [`OOO_XLEN-1:0]     pc;    // for exception data

  modport src (
    output valid, index, rd, wdata, pc
  );

  modport dst (
    input valid, index, rd, wdata, pc
  );

endinterface

`default_nettype wire

//--- logic/ooo_types_pkg.sv
// back end shared types
`default_nettype none

`include "ooo_cfg.svh"

package ooo_types_pkg;

  // ops the back end executes
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_XOR = 3'd2,
    OP_MUL = 3'd3, // only op routed to the multiplier
    OP_BEQ = 3'd4,
    OP_JAL = 3'd5
  } op_t;

  // meaning of an alu result at writeback
  typedef enum logic [1:0] {
    RES_REG    = 2'd0,
    RES_BRANCH = 2'd1,
    RES_JUMP   = 2'd2
  } res_kind_t;

  // decoded instruction, operands already read
  typedef struct packed {
    op_t                 op;
    logic [4:0]          rd;
    logic [`OOO_XLEN-1:0] pc;
    logic [`OOO_XLEN-1:0] src_a;
    logic [`OOO_XLEN-1:0] src_b;
    logic [`OOO_XLEN-1:0] imm; // branch / jump offset
    logic                pred_taken;
  } issue_t;

endpackage

`default_nettype wire

//--- logic/ooo_cfg.svh
// back end sizing
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// data and pc width
`define OOO_XLEN 32

// completion buffer entries and index width
`define OOO_CB_DEPTH 8
`define OOO_CB_IDX_W 3

// multiplier pipeline registers
`define OOO_MUL_STAGES 3

`endif
